// ==== Makefile ====
# Verilator build and run for the router output port testbench

VERILATOR  ?= verilator
TOP        ?= tbRouterOutputPort
RTL_TOP    ?= routerOutputPort
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tbRouterOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort
  import nocPkg::*;
;

  logic       clk;
  logic       rst;
  portVec_t   req;
  portFlits_t inFlits;
  portVec_t   grant;
  flit_t      outFlit;
  logic       outValid;

  // stimulus table, one entry per cycle
  portVec_t   reqQ[$];
  portFlits_t flitQ[$];
  portVec_t   expQ[$];
  int         testQ[$];
  string      testNames[$];

  logic [LengthWidth-1:0] hdrLen [NumPorts];
  int curTest = -1;
  int cycleCount = 0;
  int cycleLimit = 0;
  bit tableReady = 1'b0;

  routerOutputPort dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inFlits  (inFlits),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic beginTest(input string name);
    testNames.push_back(name);
    curTest++;
  endtask

  task automatic setLength(input portIdx_e port, input int n);
    hdrLen[port] = LengthWidth'(n);
  endtask

  // header ports carry their pending length, the others random body data
  task automatic addRows(input int n, input portVec_t r, input portVec_t hdr);
    portFlits_t rowFlits;
    flit_t      f;
    for (int k = 0; k < n; k++)
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        f.flitId = 3'd2;
        f.payload.data = 12'($urandom);
        if (hdr[p])
        begin
          f.flitId = FlitIdHeader;
          f.payload.length = hdrLen[p];
        end
        rowFlits[p] = f;
      end
      reqQ.push_back(r);
      flitQ.push_back(rowFlits);
      testQ.push_back(curTest);
    end
  endtask

  // reference model of rotation and hold time, one step per table row
  task automatic computeExpected();
    int                     holder;
    int                     nextHolder;
    int                     start;
    int                     span;
    int                     p;
    bit                     keep;
    logic [LengthWidth-1:0] cnt [NumPorts];
    logic [LengthWidth-1:0] len [NumPorts];
    holder = -1;
    for (int q = 0; q < NumPorts; q++)
    begin
      cnt[q] = '0;
      len[q] = '0;
    end
    for (int k = 0; k < reqQ.size(); k++)
    begin
      keep = 1'b0;
      if (holder >= 0)
      begin
        keep = reqQ[k][holder] && (cnt[holder] != len[holder]);
      end
      nextHolder = keep ? holder : -1;
      if (!keep)
      begin
        start = (holder < 0) ? 0 : holder + 1;
        span = (holder < 0) ? NumPorts : NumPorts - 1;
        for (int i = 0; i < span; i++)
        begin
          p = (start + i) % NumPorts;
          if (reqQ[k][p] && nextHolder < 0)
          begin
            nextHolder = p;
          end
        end
      end
      for (int q = 0; q < NumPorts; q++)
      begin
        cnt[q] = (keep && q == holder) ? cnt[q] + 12'd1 : '0;
        if (flitQ[k][q].flitId == FlitIdHeader)
        begin
          len[q] = flitQ[k][q].payload.length;
        end
      end
      holder = nextHolder;
      expQ.push_back((holder < 0) ? '0 : portVec_t'(1) << holder);
    end
  endtask

  task automatic buildTable();
    beginTest("reset");
    addRows(2, 5'b00000, 5'b00000);
    beginTest("fixed order from idle");
    setLength(PortLocal, 2);
    setLength(PortNorth, 0);
    setLength(PortEast, 1);
    setLength(PortWest, 3);
    setLength(PortSouth, 1);
    addRows(1, 5'b00000, 5'b11111);
    addRows(3, 5'b11100, 5'b00000);
    addRows(2, 5'b00000, 5'b00000);
    addRows(2, 5'b11010, 5'b00000);
    addRows(2, 5'b00000, 5'b00000);
    beginTest("rotation");
    addRows(16, 5'b11111, 5'b00000);
    addRows(2, 5'b00000, 5'b00000);
    beginTest("west to local");
    addRows(10, 5'b01001, 5'b00000);
    addRows(2, 5'b00000, 5'b00000);
    beginTest("hold time");
    setLength(PortSouth, 4);
    addRows(1, 5'b00000, 5'b10000);
    addRows(8, 5'b10000, 5'b00000);
    setLength(PortNorth, 0);
    addRows(1, 5'b00000, 5'b00010);
    addRows(4, 5'b00010, 5'b00000);
    addRows(2, 5'b00000, 5'b00000);
    beginTest("release");
    setLength(PortLocal, 9);
    addRows(1, 5'b00000, 5'b00001);
    addRows(3, 5'b00101, 5'b00000);
    addRows(3, 5'b00100, 5'b00000);
    addRows(2, 5'b00000, 5'b00000);
    beginTest("header through switch");
    setLength(PortWest, 2);
    addRows(3, 5'b01000, 5'b01000);
    addRows(2, 5'b00000, 5'b00000);
  endtask

  // the run ends here if the table loop stalls
  initial
  begin
    wait (tableReady);
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    portVec_t prevGrant;
    flit_t    expFlit;
    int       testErrors;
    int       passCount;
    int       failCount;
    testErrors = 0;
    passCount = 0;
    failCount = 0;
    rst = 1'b1;
    req = '0;
    inFlits = '0;
    void'($urandom(32'he6ce_e3f5));
    buildTable();
    computeExpected();
    cycleLimit = reqQ.size() + 2 + 20;
    tableReady = 1'b1;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int k = 0; k < reqQ.size(); k++)
    begin
      req = reqQ[k];
      inFlits = flitQ[k];
      @(negedge clk);
      // the switch shows what the previous grant selected from this row
      prevGrant = (k == 0) ? '0 : expQ[k-1];
      expFlit = '0;
      for (int p = 0; p < NumPorts; p++)
      begin
        if (prevGrant[p])
        begin
          expFlit = flitQ[k][p];
        end
      end
      if (grant !== expQ[k])
      begin
        $display("Error at %0t: grant expected %b, got %b", $time, expQ[k], grant);
        testErrors++;
      end
      if (outValid !== |prevGrant)
      begin
        $display("Error at %0t: outValid expected %b, got %b", $time, |prevGrant, outValid);
        testErrors++;
      end
      if (outFlit !== expFlit)
      begin
        $display("Error at %0t: outFlit expected %h, got %h", $time, expFlit, outFlit);
        testErrors++;
      end
      if (k == reqQ.size() - 1 || testQ[k+1] != testQ[k])
      begin
        if (testErrors == 0)
        begin
          $display("test %s: passed", testNames[testQ[k]]);
          passCount++;
        end
        else
        begin
          $display("test %s: failed with %0d errors", testNames[testQ[k]], testErrors);
          failCount++;
        end
        testErrors = 0;
      end
    end

    $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/grantTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantTimer
  import nocPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t flit,
  input  logic  runTimer,
  output logic  timesUp
);

  logic [LengthWidth-1:0] holdLength;
  logic [LengthWidth-1:0] holdCount;

  // a header flit on the port sets the hold length, granted or not
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLength <= '0;
    end
    else if (flit.flitId == FlitIdHeader)
    begin
      holdLength <= flit.payload.length;
    end
  end

  // counts held cycles and falls back to zero as soon as the hold ends
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdCount <= '0;
    end
    else if (runTimer)
    begin
      holdCount <= holdCount + 1'b1;
    end
    else
    begin
      holdCount <= '0;
    end
  end

  // with a zero length the holder gets a single grant cycle
  assign timesUp = (holdCount == holdLength);

endmodule

`default_nettype wire

// ==== hdl/nocPkg.sv ====
`default_nettype none

package nocPkg;

  // number of input ports competing for this output
  localparam int NumPorts = 5;

  // port position, also the bit position in every port vector
  typedef enum logic [2:0] {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortWest  = 3'd3,
    PortSouth = 3'd4
  } portIdx_e;

  // one bit per input port
  typedef logic [NumPorts-1:0] portVec_t;

  localparam int FlitIdWidth = 3;

  // identifier of a header flit; every other value is body or tail
  localparam logic [FlitIdWidth-1:0] FlitIdHeader = 3'd1;

  // packet length and hold counter width
  localparam int LengthWidth = 12;

  // a header carries the hold length in cycles, body and tail carry data
  typedef union packed {
    logic [LengthWidth-1:0] length;
    logic [LengthWidth-1:0] data;
  } flitPayload_u;

  typedef struct packed {
    logic [FlitIdWidth-1:0] flitId;
    flitPayload_u           payload;
  } flit_t;

  // current flit of each input, indexed by port position
  typedef flit_t [NumPorts-1:0] portFlits_t;

endpackage

`default_nettype wire

// ==== hdl/outputArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
  import nocPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portVec_t   req,
  input  portFlits_t inFlits,
  output portVec_t   grant
);

  // bit 0 is idle, bit p+1 means port p holds the output
  typedef logic [NumPorts:0] arbState_t;

  localparam arbState_t StateIdle  = arbState_t'(1);
  localparam arbState_t StateLocal = arbState_t'(1) << (PortLocal + 1);
  localparam arbState_t StateNorth = arbState_t'(1) << (PortNorth + 1);
  localparam arbState_t StateEast  = arbState_t'(1) << (PortEast + 1);
  localparam arbState_t StateWest  = arbState_t'(1) << (PortWest + 1);
  localparam arbState_t StateSouth = arbState_t'(1) << (PortSouth + 1);

  arbState_t stateReg;
  arbState_t stateNext;
  portVec_t  runTimer;
  portVec_t  timesUp;

  // scans span ports starting at first and wrapping after South,
  // the earliest requester in that order wins
  function automatic arbState_t scanFrom(
    input portIdx_e    first,
    input int unsigned span,
    input portVec_t    reqs
  );
    arbState_t   pick;
    int unsigned idx;
    int unsigned pos;
    pick = StateIdle;
    for (idx = span; idx > 0; idx--)
    begin
      pos = (int'(first) + idx - 1) % NumPorts;
      if (reqs[pos])
      begin
        pick = arbState_t'(1) << (pos + 1);
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    grantTimer timer (
      .clk      (clk),
      .rst      (rst),
      .flit     (inFlits[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stateReg <= StateIdle;
    end
    else
    begin
      stateReg <= stateNext;
    end
  end

  // a holder keeps the port while it requests and has time left,
  // otherwise the port passes on without re-checking the holder
  always_comb
  begin
    runTimer  = '0;
    stateNext = StateIdle;
    case (stateReg)
      StateIdle:
      begin
        stateNext = scanFrom(PortLocal, NumPorts, req);
      end
      StateLocal:
      begin
        if (req[PortLocal] && !timesUp[PortLocal])
        begin
          runTimer[PortLocal] = 1'b1;
          stateNext = StateLocal;
        end
        else
        begin
          stateNext = scanFrom(PortNorth, NumPorts - 1, req);
        end
      end
      StateNorth:
      begin
        if (req[PortNorth] && !timesUp[PortNorth])
        begin
          runTimer[PortNorth] = 1'b1;
          stateNext = StateNorth;
        end
        else
        begin
          stateNext = scanFrom(PortEast, NumPorts - 1, req);
        end
      end
      StateEast:
      begin
        if (req[PortEast] && !timesUp[PortEast])
        begin
          runTimer[PortEast] = 1'b1;
          stateNext = StateEast;
        end
        else
        begin
          stateNext = scanFrom(PortWest, NumPorts - 1, req);
        end
      end
      StateWest:
      begin
        // West rotates through South and then Local like every other holder
        if (req[PortWest] && !timesUp[PortWest])
        begin
          runTimer[PortWest] = 1'b1;
          stateNext = StateWest;
        end
        else
        begin
          stateNext = scanFrom(PortSouth, NumPorts - 1, req);
        end
      end
      StateSouth:
      begin
        if (req[PortSouth] && !timesUp[PortSouth])
        begin
          runTimer[PortSouth] = 1'b1;
          stateNext = StateSouth;
        end
        else
        begin
          stateNext = scanFrom(PortLocal, NumPorts - 1, req);
        end
      end
      default:
      begin
        // a corrupted state recovers through idle
        stateNext = StateIdle;
      end
    endcase
  end

  assign grant = stateReg[NumPorts:1];

endmodule

`default_nettype wire

// ==== hdl/outputSwitch.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputSwitch
  import nocPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portVec_t   grant,
  input  portFlits_t inFlits,
  output flit_t      outFlit,
  output logic       outValid
);

  flit_t selFlit;

  // grant is one-hot or zero, so an AND-OR mux is enough
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
      begin
        selFlit = selFlit | inFlits[p];
      end
    end
  end

  // the link always accepts, so the selected flit is simply registered
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= |grant;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
  import nocPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portVec_t   req,
  input  portFlits_t inFlits,
  output portVec_t   grant,
  output flit_t      outFlit,
  output logic       outValid
);

  // grant from the arbiter also steers the switch one cycle later
  portVec_t arbGrant;

  outputArbiter arbiter (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .inFlits (inFlits),
    .grant   (arbGrant)
  );

  outputSwitch switch (
    .clk      (clk),
    .rst      (rst),
    .grant    (arbGrant),
    .inFlits  (inFlits),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  assign grant = arbGrant;

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/nocPkg.sv
hdl/grantTimer.sv
hdl/outputArbiter.sv
hdl/outputSwitch.sv
hdl/routerOutputPort.sv
dv/tbRouterOutputPort.sv
